// File: include/soc_macros.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// soc constants shared by the RTL
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// 128 KiB of byte RAM, the next address bit selects I/O
`define RAM_ADDR_WIDTH 17

// clk cycles per uart bit, kept small for simulation
`define CLKS_PER_BIT 8

// extra cycles the core stays in reset after the system reset
`define RESET_DRAG_CYCLES 16

// I/O select that sends a byte out on Tx
`define IO_TX_SEL 3'd0

`endif

// File: logic/soc_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// soc types: vectors, bus request, FSM states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "soc_macros.svh"

package soc_pkg;
	typedef logic [7:0] byte_t;
	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [`RAM_ADDR_WIDTH-1:0] ram_addr_t;
	typedef logic [2:0] io_sel_t;

	// one bus master's request
	typedef struct packed {
		addr_t addr;
		logic  wr;
		byte_t dout;
	} mem_req_t;

	typedef enum logic [2:0] {HCI_IDLE, HCI_ADDR, HCI_DATA, HCI_READ, HCI_REPLY} hci_state_e;

	typedef enum logic [2:0] {CPU_FETCH, CPU_WAIT, CPU_EXEC, CPU_MEM, CPU_LOAD} cpu_state_e;
endpackage

// File: logic/reset_ctrl.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reset sync and core reset stretch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "soc_macros.svh"

module reset_ctrl (
	input  logic clk,
	input  logic btnC,
	output logic rst,
	output logic core_rst
);
	localparam int DRAG_W = $clog2(`RESET_DRAG_CYCLES + 1);

	logic rst_meta;
	logic [DRAG_W-1:0] drag;

	// asserts at once, releases after two clk edges
	always_ff @(posedge clk or posedge btnC)
	begin
		if (btnC)
		begin
			rst_meta <= 1'b1;
			rst <= 1'b1;
		end
		else
		begin
			rst_meta <= 1'b0;
			rst <= rst_meta;
		end
	end

	// core reset counts down once the system reset is gone
	always_ff @(posedge clk or posedge btnC)
	begin
		if (btnC)
		begin
			drag <= DRAG_W'(`RESET_DRAG_CYCLES);
			core_rst <= 1'b1;
		end
		else if (rst)
		begin
			drag <= DRAG_W'(`RESET_DRAG_CYCLES);
			core_rst <= 1'b1;
		end
		else
		begin
			if (drag != '0)
				drag <= drag - 1'b1;
			core_rst <= (drag != '0);
		end
	end

	a_core_rst_covers: assert property (@(posedge clk) rst |-> core_rst);
endmodule

// File: logic/ram.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 128 KiB byte RAM, registered read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "soc_macros.svh"

module ram import soc_pkg::*; (
	input  logic      clk,
	input  logic      en,
	input  logic      wr,
	input  ram_addr_t addr,
	input  byte_t     din,
	output byte_t     dout
);
	byte_t mem [2**`RAM_ADDR_WIDTH];

	// read returns the old byte on a write cycle
	always_ff @(posedge clk)
	begin
		if (en)
		begin
			if (wr)
				mem[addr] <= din;
			dout <= mem[addr];
		end
	end
endmodule

// File: logic/uart.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8N1 uart, receiver and transmitter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "soc_macros.svh"

module uart import soc_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  rx,
	output logic  tx,
	output logic  rx_valid,
	output byte_t rx_data,
	input  logic  tx_start,
	input  byte_t tx_data,
	output logic  tx_busy
);
	logic rx_meta;
	logic rx_sync;
	logic rx_on;
	logic [15:0] rx_cnt;
	logic [3:0] rx_bit;
	byte_t rx_shift;
	logic [15:0] tx_cnt;
	logic [3:0] tx_bit;
	logic [9:0] tx_shift;

	// bit 0 is the start bit, 9 the stop bit, sampled mid-bit
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_on <= 1'b0;
			rx_cnt <= '0;
			rx_bit <= '0;
			rx_valid <= 1'b0;
		end
		else
		begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_valid <= 1'b0;
			if (!rx_on)
			begin
				if (!rx_sync)
				begin
					rx_on <= 1'b1;
					rx_cnt <= 16'(`CLKS_PER_BIT / 2 - 1);
					rx_bit <= '0;
				end
			end
			else if (rx_cnt != '0)
				rx_cnt <= rx_cnt - 16'd1;
			else
			begin
				rx_cnt <= 16'(`CLKS_PER_BIT - 1);
				rx_bit <= rx_bit + 4'd1;
				// a start bit that went high again was a glitch
				if (rx_bit == 4'd0)
					rx_on <= !rx_sync;
				else if (rx_bit == 4'd9)
				begin
					rx_on <= 1'b0;
					rx_valid <= rx_sync;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rx_on && rx_cnt == '0)
		begin
			if (rx_bit == 4'd9)
				rx_data <= rx_shift;
			else if (rx_bit != 4'd0)
				rx_shift <= {rx_sync, rx_shift[7:1]};
		end
	end

	// frame is shifted out lsb first, ones fill behind it
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			tx_shift <= '1;
			tx_busy <= 1'b0;
			tx_cnt <= '0;
			tx_bit <= '0;
		end
		else if (!tx_busy)
		begin
			if (tx_start)
			begin
				tx_busy <= 1'b1;
				tx_shift <= {1'b1, tx_data, 1'b0};
				tx_cnt <= 16'(`CLKS_PER_BIT - 1);
				tx_bit <= '0;
			end
		end
		else if (tx_cnt != '0)
			tx_cnt <= tx_cnt - 16'd1;
		else if (tx_bit == 4'd9)
			tx_busy <= 1'b0;
		else
		begin
			tx_shift <= {1'b1, tx_shift[9:1]};
			tx_cnt <= 16'(`CLKS_PER_BIT - 1);
			tx_bit <= tx_bit + 4'd1;
		end
	end

	assign tx = tx_shift[0];

	a_no_start_busy: assert property (@(posedge clk) disable iff (rst) tx_start |-> !tx_busy);
endmodule

// File: logic/hci.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host command interface: debug break, RAM access, I/O transmit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "soc_macros.svh"

module hci import soc_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     rx,
	output logic     tx,
	output logic     active,
	output mem_req_t hci_req,
	input  byte_t    ram_din,
	input  logic     io_en,
	input  io_sel_t  io_sel,
	input  logic     io_wr,
	input  byte_t    io_din,
	output byte_t    io_dout,
	output logic     io_busy
);
	hci_state_e state;
	logic rx_valid;
	byte_t rx_data;
	logic tx_start;
	byte_t tx_data;
	logic tx_busy;
	logic [1:0] cnt;
	logic cmd_wr;
	logic wr_q;
	addr_t haddr;
	byte_t hdata;
	logic tx_free;
	logic io_hit;
	logic io_go;
	logic reply_go;

	uart u_uart (
		.clk(clk),
		.rst(rst),
		.rx(rx),
		.tx(tx),
		.rx_valid(rx_valid),
		.rx_data(rx_data),
		.tx_start(tx_start),
		.tx_data(tx_data),
		.tx_busy(tx_busy)
	);

	// transmitter is free once no start is pending and no frame runs
	assign tx_free = !tx_busy && !tx_start;
	assign io_hit = io_en && io_wr && (io_sel == io_sel_t'(`IO_TX_SEL)) && !active;
	assign io_go = io_hit && tx_free;
	assign io_busy = io_hit && !tx_free;
	assign reply_go = (state == HCI_REPLY) && tx_free && !io_hit;
	// I/O reads return zero
	assign io_dout = '0;
	assign hci_req = '{addr: haddr, wr: wr_q, dout: hdata};

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= HCI_IDLE;
			active <= 1'b1;
			cnt <= '0;
			cmd_wr <= 1'b0;
			wr_q <= 1'b0;
			tx_start <= 1'b0;
			haddr <= '0;
		end
		else
		begin
			wr_q <= 1'b0;
			tx_start <= io_go || reply_go;
			case (state)
			HCI_IDLE:
				if (rx_valid)
				begin
					cnt <= '0;
					case (rx_data)
					8'h01:
					begin
						cmd_wr <= 1'b1;
						state <= HCI_ADDR;
					end
					8'h02:
					begin
						cmd_wr <= 1'b0;
						state <= HCI_ADDR;
					end
					8'h03: active <= 1'b0;
					8'h04: active <= 1'b1;
					default: ;
					endcase
				end
			HCI_ADDR:
				if (rx_valid)
				begin
					// three address bytes, msb first
					haddr <= {8'h00, haddr[15:0], rx_data};
					cnt <= cnt + 2'd1;
					if (cnt == 2'd2)
						state <= cmd_wr ? HCI_DATA : HCI_READ;
				end
			HCI_DATA:
				if (rx_valid)
				begin
					wr_q <= 1'b1;
					state <= HCI_IDLE;
				end
			// RAM data shows up one cycle after the address
			HCI_READ: state <= HCI_REPLY;
			HCI_REPLY:
				if (reply_go)
					state <= HCI_IDLE;
			default: state <= HCI_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (rx_valid && state == HCI_DATA)
			hdata <= rx_data;
		if (io_go)
			tx_data <= io_din;
		else if (reply_go)
			tx_data <= ram_din;
	end

	a_wr_in_break: assert property (@(posedge clk) disable iff (rst) hci_req.wr |-> active);
endmodule

// File: logic/cpu.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// multi-cycle RV32I subset core on the byte bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module cpu import soc_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     rdy,
	input  byte_t    mem_din,
	output mem_req_t cpu_req
);
	localparam logic [6:0] OP_LUI = 7'b0110111;
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_LOAD = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_JAL = 7'b1101111;

	cpu_state_e state;
	addr_t pc;
	addr_t next_pc;
	logic [1:0] cnt;
	word_t ir;
	word_t regs [32];
	word_t rs1_val;
	word_t rs2_val;
	word_t imm_i;
	word_t imm_s;
	word_t imm_u;
	word_t imm_j;
	word_t rf_wd;
	logic rf_we;
	logic [4:0] rd;
	logic is_lbu;
	logic is_sb;

	assign rd = ir[11:7];
	// x0 always reads zero
	assign rs1_val = (ir[19:15] == 5'd0) ? '0 : regs[ir[19:15]];
	assign rs2_val = (ir[24:20] == 5'd0) ? '0 : regs[ir[24:20]];
	assign imm_i = {{20{ir[31]}}, ir[31:20]};
	assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
	assign imm_u = {ir[31:12], 12'd0};
	assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
	assign is_lbu = (ir[6:0] == OP_LOAD) && (ir[14:12] == 3'b100);
	assign is_sb = (ir[6:0] == OP_STORE) && (ir[14:12] == 3'b000);

	// writeback and next pc, unknown opcodes just step over
	always_comb
	begin
		next_pc = pc + 32'd4;
		rf_we = 1'b0;
		rf_wd = imm_u;
		if (state == CPU_EXEC)
		begin
			case (ir[6:0])
			OP_LUI: rf_we = 1'b1;
			OP_IMM:
			begin
				rf_we = (ir[14:12] == 3'b000);
				rf_wd = rs1_val + imm_i;
			end
			OP_JAL:
			begin
				rf_we = 1'b1;
				rf_wd = pc + 32'd4;
				next_pc = pc + imm_j;
			end
			default: ;
			endcase
		end
		else if (state == CPU_LOAD && is_lbu)
		begin
			rf_we = 1'b1;
			rf_wd = {24'd0, mem_din};
		end
		rf_we = rf_we && rdy && (rd != 5'd0);
	end

	always_ff @(posedge clk)
	begin
		if (rf_we)
			regs[rd] <= rf_wd;
	end

	// fetch is pipelined: address k goes out while byte k-1 comes back
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= CPU_FETCH;
			pc <= '0;
			cnt <= '0;
			ir <= '0;
			cpu_req <= '0;
		end
		else if (rdy)
		begin
			case (state)
			CPU_FETCH:
			begin
				if (cnt != 2'd0)
					ir <= {mem_din, ir[31:8]};
				if (cnt == 2'd3)
					state <= CPU_WAIT;
				else
					cpu_req.addr <= pc + addr_t'(cnt) + 32'd1;
				cnt <= cnt + 2'd1;
			end
			CPU_WAIT:
			begin
				ir <= {mem_din, ir[31:8]};
				state <= CPU_EXEC;
			end
			CPU_EXEC:
				if (is_lbu || is_sb)
				begin
					cpu_req.addr <= rs1_val + (is_sb ? imm_s : imm_i);
					cpu_req.wr <= is_sb;
					cpu_req.dout <= rs2_val[7:0];
					state <= CPU_MEM;
				end
				else
				begin
					pc <= next_pc;
					cpu_req.addr <= next_pc;
					state <= CPU_FETCH;
				end
			CPU_MEM:
			begin
				pc <= next_pc;
				cpu_req.addr <= next_pc;
				cpu_req.wr <= 1'b0;
				state <= CPU_LOAD;
			end
			// load data arrives here, writeback is in the comb block
			CPU_LOAD: state <= CPU_FETCH;
			default: state <= CPU_FETCH;
			endcase
		end
	end

	a_req_hold: assert property (@(posedge clk) disable iff (rst) !rdy |=> $stable(cpu_req));
endmodule

// File: logic/riscv_top.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// soc top: bus mux, address decode, core pause
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "soc_macros.svh"

module riscv_top import soc_pkg::*; (
	input  logic clk,
	input  logic btnC,
	input  logic Rx,
	output logic Tx,
	output logic led
);
	logic rst;
	logic core_rst;
	logic cpu_rst;
	logic cpu_rdy;
	logic hci_active;
	logic io_busy;
	logic ram_en;
	logic io_en;
	logic io_rd_q;
	io_sel_t io_sel;
	mem_req_t cpu_req;
	mem_req_t hci_req;
	mem_req_t bus_req;
	byte_t ram_dout;
	byte_t io_dout;
	byte_t cpu_din;

	reset_ctrl u_reset_ctrl (.clk(clk), .btnC(btnC), .rst(rst), .core_rst(core_rst));

	// host owns the bus during debug break
	assign bus_req = hci_active ? hci_req : cpu_req;
	assign ram_en = !bus_req.addr[`RAM_ADDR_WIDTH];
	assign io_en = bus_req.addr[`RAM_ADDR_WIDTH];
	assign io_sel = bus_req.addr[2:0];

	ram u_ram (
		.clk(clk),
		.en(ram_en),
		.wr(bus_req.wr),
		.addr(bus_req.addr[`RAM_ADDR_WIDTH-1:0]),
		.din(bus_req.dout),
		.dout(ram_dout)
	);

	// read data is a cycle late, so pick its source by the previous decode
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			io_rd_q <= 1'b0;
		else
			io_rd_q <= io_en;
	end
	assign cpu_din = io_rd_q ? io_dout : ram_dout;

	assign cpu_rdy = !(hci_active || io_busy);
	// break also holds the core in reset, so run restarts it at address 0
	assign cpu_rst = core_rst || hci_active;

	cpu u_cpu (.clk(clk), .rst(cpu_rst), .rdy(cpu_rdy), .mem_din(cpu_din), .cpu_req(cpu_req));

	hci u_hci (
		.clk(clk),
		.rst(rst),
		.rx(Rx),
		.tx(Tx),
		.active(hci_active),
		.hci_req(hci_req),
		.ram_din(ram_dout),
		.io_en(io_en),
		.io_sel(io_sel),
		.io_wr(bus_req.wr),
		.io_din(bus_req.dout),
		.io_dout(io_dout),
		.io_busy(io_busy)
	);

	assign led = hci_active;
endmodule

// File: verification/tb_clock.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock, 4 ns period
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_clock (
	output logic clk
);
	initial clk = 1'b0;

	always #2 clk = ~clk;
endmodule

// File: verification/tb_riscv_top.sv
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// soc testbench: uart host model, small programs, checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "soc_macros.svh"

module tb_riscv_top;
	localparam logic [31:0] SEED = 32'h5a1dcb56;
	localparam int RX_TIMEOUT = 4000;
	localparam int LED_TIMEOUT = 400;

	logic clk;
	logic btn_c;
	logic rx;
	logic tx;
	logic led;
	int errors;
	int timeouts;
	logic [23:0] addrs [8];
	logic [7:0] datas [8];

	tb_clock u_tb_clock (.clk(clk));

	riscv_top u_riscv_top (.clk(clk), .btnC(btn_c), .Rx(rx), .Tx(tx), .led(led));

	// RV32I encodings
	function automatic logic [31:0] addi_insn(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] lui_insn(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, 7'b0110111};
	endfunction

	function automatic logic [31:0] lbu_insn(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm, rs1, 3'b100, rd, 7'b0000011};
	endfunction

	function automatic logic [31:0] sb_insn(input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] jal_insn(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] got);
		assert (got === exp) else
		begin
			$display("Error %s: expected %02h, actual %02h", name, exp, got);
			errors++;
		end
	endtask

	// leading idle gap doubles as the stop bit of the previous frame
	task automatic send_byte(input logic [7:0] b);
		int i;
		repeat (2 * `CLKS_PER_BIT) @(posedge clk);
		rx <= 1'b0;
		repeat (`CLKS_PER_BIT) @(posedge clk);
		for (i = 0; i < 8; i++)
		begin
			rx <= b[i];
			repeat (`CLKS_PER_BIT) @(posedge clk);
		end
		rx <= 1'b1;
	endtask

	// waits for a start bit, then samples each bit in its middle
	task automatic recv_byte(input string name, output logic [7:0] b);
		int n;
		int i;
		b = '0;
		n = 0;
		@(negedge clk);
		while (tx !== 1'b0 && n < RX_TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (tx !== 1'b0)
		begin
			$display("%s: no frame started on Tx within %0d cycles", name, RX_TIMEOUT);
			timeouts++;
		end
		else
		begin
			repeat (`CLKS_PER_BIT / 2) @(negedge clk);
			assert (tx === 1'b0) else
			begin
				$display("%s: start bit on Tx was too short", name);
				errors++;
			end
			for (i = 0; i < 8; i++)
			begin
				repeat (`CLKS_PER_BIT) @(negedge clk);
				b[i] = tx;
			end
			repeat (`CLKS_PER_BIT) @(negedge clk);
			assert (tx === 1'b1) else
			begin
				$display("%s: stop bit on Tx was missing", name);
				errors++;
			end
		end
	endtask

	task automatic idle_check(input string name, input int cycles);
		int lows;
		lows = 0;
		repeat (cycles)
		begin
			@(negedge clk);
			if (tx !== 1'b1)
				lows++;
		end
		assert (lows == 0) else
		begin
			$display("%s: Tx left idle in %0d of %0d cycles", name, lows, cycles);
			errors++;
		end
	endtask

	task automatic wait_led(input string name, input logic exp);
		int n;
		n = 0;
		@(negedge clk);
		while (led !== exp && n < LED_TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		check_val(name, {7'd0, exp}, {7'd0, led});
	endtask

	task automatic write_ram(input logic [23:0] addr, input logic [7:0] data);
		send_byte(8'h01);
		send_byte(addr[23:16]);
		send_byte(addr[15:8]);
		send_byte(addr[7:0]);
		send_byte(data);
	endtask

	task automatic read_ram(input string name, input logic [23:0] addr, output logic [7:0] data);
		send_byte(8'h02);
		send_byte(addr[23:16]);
		send_byte(addr[15:8]);
		send_byte(addr[7:0]);
		recv_byte(name, data);
	endtask

	// little-endian, lowest byte at the lowest address
	task automatic load_word(input logic [23:0] addr, input logic [31:0] word);
		write_ram(addr, word[7:0]);
		write_ram(addr + 24'd1, word[15:8]);
		write_ram(addr + 24'd2, word[23:16]);
		write_ram(addr + 24'd3, word[31:24]);
	endtask

	initial
	begin
		logic [31:0] r;
		logic [7:0] got;
		logic [7:0] imm8;
		logic [7:0] ld_byte;
		logic [7:0] exp_byte;
		int i;
		btn_c = 1'b1;
		rx = 1'b1;
		errors = 0;
		timeouts = 0;
		r = $urandom(SEED);
		repeat (10) @(posedge clk);
		btn_c <= 1'b0;

		// state after reset
		idle_check("reset idle", 50);
		check_val("reset led", 8'd1, {7'd0, led});

		// random RAM bytes, low address bits keep the addresses distinct
		for (i = 0; i < 8; i++)
		begin
			r = $urandom;
			addrs[i] = {7'd0, r[16:3], 3'(i)};
			r = $urandom;
			datas[i] = r[7:0];
			write_ram(addrs[i], datas[i]);
		end
		for (i = 0; i < 8; i++)
		begin
			read_ram($sformatf("ram readback %0d", i), addrs[i], got);
			check_val($sformatf("ram readback %0d", i), datas[i], got);
		end

		// run and break, with a parking loop at address 0
		load_word(24'h0, jal_insn(5'd0, 21'd0));
		send_byte(8'h03);
		wait_led("run led", 1'b0);
		send_byte(8'h04);
		wait_led("break led", 1'b1);

		// store an immediate to I/O
		r = $urandom;
		imm8 = r[7:0];
		load_word(24'h0, addi_insn(5'd1, 5'd0, {4'd0, imm8}));
		load_word(24'h4, lui_insn(5'd2, 20'h00020));
		load_word(24'h8, sb_insn(5'd1, 5'd2, 12'd0));
		load_word(24'hc, jal_insn(5'd0, 21'd0));
		send_byte(8'h03);
		recv_byte("io store", got);
		check_val("io store", imm8, got);
		idle_check("io store single frame", 200);

		// load, increment, store to RAM and I/O
		send_byte(8'h04);
		wait_led("second break led", 1'b1);
		r = $urandom;
		ld_byte = r[7:0];
		exp_byte = ld_byte + 8'd1;
		write_ram(24'h100, ld_byte);
		load_word(24'h0, lbu_insn(5'd1, 5'd0, 12'h100));
		load_word(24'h4, addi_insn(5'd1, 5'd1, 12'd1));
		load_word(24'h8, lui_insn(5'd2, 20'h00020));
		load_word(24'hc, sb_insn(5'd1, 5'd0, 12'h104));
		load_word(24'h10, sb_insn(5'd1, 5'd2, 12'd0));
		load_word(24'h14, jal_insn(5'd0, 21'd0));
		send_byte(8'h03);
		recv_byte("load add store", got);
		check_val("load add store", exp_byte, got);

		// the RAM copy survives the break
		send_byte(8'h04);
		wait_led("third break led", 1'b1);
		read_ram("ram after break", 24'h104, got);
		check_val("ram after break", exp_byte, got);

		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end
endmodule

// File: src.f
+incdir+include
logic/soc_pkg.sv
logic/reset_ctrl.sv
logic/ram.sv
logic/uart.sv
logic/hci.sv
logic/cpu.sv
logic/riscv_top.sv
verification/tb_clock.sv
verification/tb_riscv_top.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_riscv_top -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Finished with no errors" sim.log; then
	exit 0
fi
exit 1
